// ==== sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

    // wait counts loaded into the delay counter
    localparam int T_PRE       = 2;
    localparam int T_ACT       = 2;
    localparam int T_REF       = 6;
    localparam int T_WR        = 1;
    localparam int CAS_LATENCY = 3;   // READ on pins to data on dqi

    localparam logic [9:0] REFRESH_INTERVAL = 10'd750;

    // address map, user address is {row, bank, col}
    localparam int ADDR_W    = 23;
    localparam int ROW_W     = 13;
    localparam int BANK_W    = 2;
    localparam int COL_W     = 8;
    localparam int DATA_W    = 32;
    localparam int NUM_BANKS = 4;

    localparam int DELAY_W = $clog2(T_REF + 1);

    // cs, ras, cas, we
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001
    } sdram_cmd_e;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_WAIT,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_READ,
        ST_WRITE,
        ST_PRECHARGE
    } sdram_state_e;

    typedef enum logic [1:0] {
        ROW_HIT,
        ROW_MISS,
        ROW_CLOSED
    } row_status_e;

    typedef struct packed {
        logic [ROW_W-1:0]  row;
        logic [BANK_W-1:0] bank;
        logic [COL_W-1:0]  col;
    } sdram_addr_t;

    typedef struct packed {
        logic              rw;     // 1 = write
        sdram_addr_t       addr;
        logic [DATA_W-1:0] data;
    } sdram_req_t;

    // everything that goes out to the pins in one cycle
    typedef struct packed {
        sdram_cmd_e        cmd;
        logic [BANK_W-1:0] ba;
        logic [ROW_W-1:0]  a;
        logic              dq_en;
        logic [DATA_W-1:0] dq;
    } sdram_pin_cmd_t;

endpackage

`default_nettype wire

// ==== sdram_req_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_req_latch import sdram_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_in_valid,
    input  wire logic              i_rw,
    input  wire logic [ADDR_W-1:0] i_addr,
    input  wire logic [DATA_W-1:0] i_data,
    input  wire logic              i_take,
    output sdram_req_t             o_req,
    output logic                   o_pending,
    output logic                   o_busy
);

    logic       init_q;     // first cycle after reset
    logic       ready_q;
    logic       pending_q;
    sdram_req_t req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            init_q    <= 1'b0;
            ready_q   <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            init_q <= 1'b1;
            if (ready_q && i_in_valid) begin
                pending_q <= 1'b1;
                ready_q   <= 1'b0;
            end else if (i_take) begin
                pending_q <= 1'b0;   // slot free again
                ready_q   <= 1'b1;
            end else if (init_q && !pending_q) begin
                ready_q <= 1'b1;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (ready_q && i_in_valid) begin
            req_q.rw   <= i_rw;
            req_q.addr <= sdram_addr_t'(i_addr);  // flat address is {row, bank, col}
            req_q.data <= i_data;
        end
    end

    assign o_req     = req_q;
    assign o_pending = pending_q;
    assign o_busy    = !ready_q;

endmodule

`default_nettype wire

// ==== sdram_refresh_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_timer import sdram_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic i_ack,
    output logic      o_due
);

    logic [9:0] cnt_q;
    logic       due_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
            due_q <= 1'b0;
        end else if (i_ack) begin
            // restart the interval from the refresh
            cnt_q <= '0;
            due_q <= 1'b0;
        end else if (cnt_q == REFRESH_INTERVAL - 10'd1) begin
            cnt_q <= '0;
            due_q <= 1'b1;   // sticky until acked
        end else begin
            cnt_q <= cnt_q + 10'd1;
        end
    end

    assign o_due = due_q;

endmodule

`default_nettype wire

// ==== sdram_bank_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_bank_tracker import sdram_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  sdram_addr_t            i_addr,
    input  wire logic              i_open,
    input  sdram_addr_t            i_open_addr,
    input  wire logic              i_close_bank,
    input  wire logic [BANK_W-1:0] i_close_sel,
    input  wire logic              i_close_all,
    output row_status_e            o_status
);

    logic [NUM_BANKS-1:0] open_q;
    logic [ROW_W-1:0]     row_q [NUM_BANKS];

    // open bits
    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else if (i_close_all) begin
            open_q <= '0;
        end else if (i_close_bank) begin
            open_q[i_close_sel] <= 1'b0;
        end else if (i_open) begin
            open_q[i_open_addr.bank] <= 1'b1;
        end
    end

    // row of each bank, only meaningful while its open bit is set
    always_ff @(posedge clk) begin
        if (i_open) begin
            row_q[i_open_addr.bank] <= i_open_addr.row;
        end
    end

    always_comb begin
        if (!open_q[i_addr.bank]) begin
            o_status = ROW_CLOSED;
        end else if (row_q[i_addr.bank] == i_addr.row) begin
            o_status = ROW_HIT;
        end else begin
            o_status = ROW_MISS;     // other row open, needs precharge
        end
    end

endmodule

`default_nettype wire

// ==== sdram_cmd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_sequencer import sdram_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  sdram_req_t              i_req,
    input  wire logic               i_pending,
    input  row_status_e             i_status,
    input  wire logic               i_refresh_due,
    output logic                    o_take,
    output logic                    o_refresh_ack,
    output logic                    o_open,
    output sdram_addr_t             o_open_addr,
    output logic                    o_close_bank,
    output logic [BANK_W-1:0]       o_close_sel,
    output logic                    o_close_all,
    output logic                    o_read_issued,
    output logic                    o_cle,
    output sdram_pin_cmd_t          o_pin
);

    sdram_state_e         state_q, state_d;
    sdram_state_e         next_q, next_d;    // where WAIT goes when the delay ends
    logic [DELAY_W-1:0]   delay_q, delay_d;
    logic                 cle_q, cle_d;
    logic                 pre_all_q, pre_all_d;
    logic [BANK_W-1:0]    pre_bank_q, pre_bank_d;
    sdram_req_t           cur_q, cur_d;      // request being served

    always_comb begin
        state_d    = state_q;
        next_d     = next_q;
        delay_d    = delay_q;
        cle_d      = cle_q;
        pre_all_d  = pre_all_q;
        pre_bank_d = pre_bank_q;
        cur_d      = cur_q;

        o_take        = 1'b0;
        o_refresh_ack = 1'b0;
        o_open        = 1'b0;
        o_close_bank  = 1'b0;
        o_close_all   = 1'b0;
        o_read_issued = 1'b0;

        o_pin.cmd   = CMD_NOP;
        o_pin.ba    = '0;
        o_pin.a     = '0;
        o_pin.dq_en = 1'b0;
        o_pin.dq    = '0;

        case (state_q)
            ST_INIT: begin
                // power-up sequence skipped, clock enable and go idle
                cle_d   = 1'b1;
                delay_d = '0;
                next_d  = ST_IDLE;
                state_d = ST_WAIT;
            end

            ST_WAIT: begin
                if (delay_q == '0) begin
                    state_d = next_q;
                end else begin
                    delay_d = delay_q - 1'b1;
                end
            end

            ST_IDLE: begin
                if (i_refresh_due) begin
                    o_refresh_ack = 1'b1;
                    pre_all_d     = 1'b1;
                    pre_bank_d    = '0;
                    next_d        = ST_REFRESH;
                    state_d       = ST_PRECHARGE;
                end else if (i_pending) begin
                    o_take = 1'b1;
                    cur_d  = i_req;
                    case (i_status)
                        ROW_HIT: begin
                            state_d = i_req.rw ? ST_WRITE : ST_READ;
                        end
                        ROW_MISS: begin
                            pre_all_d  = 1'b0;
                            pre_bank_d = i_req.addr.bank;
                            next_d     = ST_ACTIVATE;
                            state_d    = ST_PRECHARGE;
                        end
                        default: begin
                            state_d = ST_ACTIVATE;
                        end
                    endcase
                end
            end

            ST_REFRESH: begin
                o_pin.cmd = CMD_REFRESH;
                delay_d   = DELAY_W'(T_REF - 1);   // one more cycle passes in idle
                next_d    = ST_IDLE;
                state_d   = ST_WAIT;
            end

            ST_ACTIVATE: begin
                o_pin.cmd = CMD_ACTIVE;
                o_pin.ba  = cur_q.addr.bank;
                o_pin.a   = cur_q.addr.row;
                o_open    = 1'b1;
                delay_d   = DELAY_W'(T_ACT);
                next_d    = cur_q.rw ? ST_WRITE : ST_READ;
                state_d   = ST_WAIT;
            end

            ST_READ: begin
                o_pin.cmd     = CMD_READ;
                o_pin.ba      = cur_q.addr.bank;
                o_pin.a       = {{(ROW_W-COL_W-2){1'b0}}, cur_q.addr.col, 2'b00};
                o_read_issued = 1'b1;
                delay_d       = DELAY_W'(CAS_LATENCY - 1);
                next_d        = ST_IDLE;
                state_d       = ST_WAIT;
            end

            ST_WRITE: begin
                o_pin.cmd   = CMD_WRITE;
                o_pin.ba    = cur_q.addr.bank;
                o_pin.a     = {{(ROW_W-COL_W-2){1'b0}}, cur_q.addr.col, 2'b00};
                o_pin.dq_en = 1'b1;              // drive dq only with the command
                o_pin.dq    = cur_q.data;
                delay_d     = DELAY_W'(T_WR - 1);
                next_d      = ST_IDLE;
                state_d     = ST_WAIT;
            end

            ST_PRECHARGE: begin
                o_pin.cmd     = CMD_PRECHARGE;
                o_pin.ba      = pre_bank_q;
                o_pin.a[10]   = pre_all_q;       // a10 selects all banks
                o_close_all   = pre_all_q;
                o_close_bank  = !pre_all_q;
                delay_d       = DELAY_W'(T_PRE);
                state_d       = ST_WAIT;
            end

            default: begin
                state_d = ST_INIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_INIT;
            next_q     <= ST_IDLE;
            delay_q    <= '0;
            cle_q      <= 1'b0;
            pre_all_q  <= 1'b0;
            pre_bank_q <= '0;
        end else begin
            state_q    <= state_d;
            next_q     <= next_d;
            delay_q    <= delay_d;
            cle_q      <= cle_d;
            pre_all_q  <= pre_all_d;
            pre_bank_q <= pre_bank_d;
        end
    end

    always_ff @(posedge clk) begin
        cur_q <= cur_d;
    end

    assign o_open_addr = cur_q.addr;
    assign o_close_sel = pre_bank_q;
    assign o_cle       = cle_d;    // registered once more in the pin stage

endmodule

`default_nettype wire

// ==== sdram_phy_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_phy_regs import sdram_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  sdram_pin_cmd_t         i_pin,
    input  wire logic              i_cle,
    input  wire logic              i_read_issued,
    input  wire logic [DATA_W-1:0] i_sdram_dqi,
    output logic                   o_sdram_cle,
    output logic                   o_sdram_cs,
    output logic                   o_sdram_ras,
    output logic                   o_sdram_cas,
    output logic                   o_sdram_we,
    output logic [BANK_W-1:0]      o_sdram_ba,
    output logic [ROW_W-1:0]       o_sdram_a,
    output logic [DATA_W-1:0]      o_sdram_dqo,
    output logic                   o_sdram_dq_en,
    output logic [DATA_W-1:0]      o_data_out,
    output logic                   o_out_valid
);

    sdram_cmd_e           cmd_q;
    logic                 cle_q;
    logic                 dq_en_q;
    logic [BANK_W-1:0]    ba_q;
    logic [ROW_W-1:0]     a_q;
    logic [DATA_W-1:0]    dq_q;
    logic [CAS_LATENCY:0] rd_pipe_q;    // stage 0 lines up with READ on the pins
    logic                 valid_q;
    logic [DATA_W-1:0]    data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q     <= CMD_NOP;
            cle_q     <= 1'b0;
            dq_en_q   <= 1'b0;
            rd_pipe_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            cmd_q     <= i_pin.cmd;
            cle_q     <= i_cle;
            dq_en_q   <= i_pin.dq_en;
            rd_pipe_q <= {rd_pipe_q[CAS_LATENCY-1:0], i_read_issued};
            valid_q   <= rd_pipe_q[CAS_LATENCY];   // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        ba_q <= i_pin.ba;
        a_q  <= i_pin.a;
        dq_q <= i_pin.dq;
        if (rd_pipe_q[CAS_LATENCY]) begin
            data_q <= i_sdram_dqi;   // word is on dqi this cycle
        end
    end

    assign o_sdram_cle   = cle_q;
    assign o_sdram_cs    = cmd_q[3];
    assign o_sdram_ras   = cmd_q[2];
    assign o_sdram_cas   = cmd_q[1];
    assign o_sdram_we    = cmd_q[0];
    assign o_sdram_ba    = ba_q;
    assign o_sdram_a     = a_q;
    assign o_sdram_dqo   = dq_q;
    assign o_sdram_dq_en = dq_en_q;
    assign o_data_out    = data_q;
    assign o_out_valid   = valid_q;

endmodule

`default_nettype wire

// ==== sdram_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_controller import sdram_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    // sdram pins
    output logic                   o_sdram_cle,
    output logic                   o_sdram_cs,
    output logic                   o_sdram_ras,
    output logic                   o_sdram_cas,
    output logic                   o_sdram_we,
    output logic [BANK_W-1:0]      o_sdram_ba,
    output logic [ROW_W-1:0]       o_sdram_a,
    output logic [DATA_W-1:0]      o_sdram_dqo,
    output logic                   o_sdram_dq_en,
    input  wire logic [DATA_W-1:0] i_sdram_dqi,
    // user side
    input  wire logic [ADDR_W-1:0] i_user_addr,
    input  wire logic              i_rw,          // 1 = write
    input  wire logic [DATA_W-1:0] i_data_in,
    input  wire logic              i_in_valid,
    output logic [DATA_W-1:0]      o_data_out,
    output logic                   o_busy,
    output logic                   o_out_valid
);

    sdram_req_t        req;
    logic              pending;
    logic              take;
    row_status_e       status;
    logic              refresh_due;
    logic              refresh_ack;
    logic              open;
    sdram_addr_t       open_addr;
    logic              close_bank;
    logic [BANK_W-1:0] close_sel;
    logic              close_all;
    logic              read_issued;
    logic              cle;
    sdram_pin_cmd_t    pin;

    sdram_req_latch u_req_latch (
        .clk        (clk),
        .rst        (rst),
        .i_in_valid (i_in_valid),
        .i_rw       (i_rw),
        .i_addr     (i_user_addr),
        .i_data     (i_data_in),
        .i_take     (take),
        .o_req      (req),
        .o_pending  (pending),
        .o_busy     (o_busy)
    );

    sdram_refresh_timer u_refresh_timer (
        .clk   (clk),
        .rst   (rst),
        .i_ack (refresh_ack),
        .o_due (refresh_due)
    );

    sdram_bank_tracker u_bank_tracker (
        .clk          (clk),
        .rst          (rst),
        .i_addr       (req.addr),
        .i_open       (open),
        .i_open_addr  (open_addr),
        .i_close_bank (close_bank),
        .i_close_sel  (close_sel),
        .i_close_all  (close_all),
        .o_status     (status)
    );

    sdram_cmd_sequencer u_cmd_sequencer (
        .clk           (clk),
        .rst           (rst),
        .i_req         (req),
        .i_pending     (pending),
        .i_status      (status),
        .i_refresh_due (refresh_due),
        .o_take        (take),
        .o_refresh_ack (refresh_ack),
        .o_open        (open),
        .o_open_addr   (open_addr),
        .o_close_bank  (close_bank),
        .o_close_sel   (close_sel),
        .o_close_all   (close_all),
        .o_read_issued (read_issued),
        .o_cle         (cle),
        .o_pin         (pin)
    );

    sdram_phy_regs u_phy_regs (
        .clk           (clk),
        .rst           (rst),
        .i_pin         (pin),
        .i_cle         (cle),
        .i_read_issued (read_issued),
        .i_sdram_dqi   (i_sdram_dqi),
        .o_sdram_cle   (o_sdram_cle),
        .o_sdram_cs    (o_sdram_cs),
        .o_sdram_ras   (o_sdram_ras),
        .o_sdram_cas   (o_sdram_cas),
        .o_sdram_we    (o_sdram_we),
        .o_sdram_ba    (o_sdram_ba),
        .o_sdram_a     (o_sdram_a),
        .o_sdram_dqo   (o_sdram_dqo),
        .o_sdram_dq_en (o_sdram_dq_en),
        .o_data_out    (o_data_out),
        .o_out_valid   (o_out_valid)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // reset covers three rising edges, released on a falling edge
    initial begin
        o_rst = 1'b1;
        repeat (3) @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== sdram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_model import sdram_pkg::*; (
    input  wire logic              clk,
    input  wire logic              i_cle,
    input  wire logic              i_cs,
    input  wire logic              i_ras,
    input  wire logic              i_cas,
    input  wire logic              i_we,
    input  wire logic [BANK_W-1:0] i_ba,
    input  wire logic [ROW_W-1:0]  i_a,
    input  wire logic [DATA_W-1:0] i_dq,
    input  wire logic              i_dq_en,
    output logic [DATA_W-1:0]      o_dq,
    output logic                   o_error
);

    logic [DATA_W-1:0]    mem [logic [ADDR_W-1:0]];   // sparse array
    logic                 open_q [NUM_BANKS];
    logic [ROW_W-1:0]     row_q [NUM_BANKS];
    logic [DATA_W-1:0]    rd_data [CAS_LATENCY-1];    // read return pipe
    logic                 rd_valid [CAS_LATENCY-1];
    sdram_cmd_e           last_cmd;
    int                   last_cycle;
    int                   cycle;

    // never-written words, every address bit shows up in the pattern
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr, addr[8:0]} ^ 32'h5a5a_5a5a;
    endfunction

    function automatic int min_gap(input sdram_cmd_e cmd);
        case (cmd)
            CMD_PRECHARGE: return T_PRE + 2;
            CMD_ACTIVE:    return T_ACT + 2;
            CMD_REFRESH:   return T_REF + 2;
            CMD_WRITE:     return T_WR + 2;
            CMD_READ:      return CAS_LATENCY + 2;
            default:       return 0;
        endcase
    endfunction

    task automatic flag(input string what);
        $display("SDRAM model: %s at cycle %0d", what, cycle);
        o_error <= 1'b1;
    endtask

    initial begin
        o_error    = 1'b0;
        o_dq       = 'x;
        last_cmd   = CMD_NOP;
        last_cycle = 0;
        cycle      = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            open_q[b] = 1'b0;
            row_q[b]  = '0;
        end
        for (int i = 0; i < CAS_LATENCY - 1; i++) begin
            rd_valid[i] = 1'b0;
        end
    end

    always @(posedge clk) begin
        logic [ADDR_W-1:0] key;
        sdram_cmd_e        cmd;
        cmd = sdram_cmd_e'({i_cs, i_ras, i_cas, i_we});
        key = {row_q[i_ba], i_ba, i_a[9:2]};
        cycle++;
        // read data walks toward dq, last stage drives the bus
        o_dq <= rd_valid[CAS_LATENCY-2] ? rd_data[CAS_LATENCY-2] : 'x;
        for (int i = CAS_LATENCY - 2; i > 0; i--) begin
            rd_valid[i] <= rd_valid[i-1];
            rd_data[i]  <= rd_data[i-1];
        end
        rd_valid[0] <= 1'b0;
        if (i_cle === 1'b1) begin
            if (i_dq_en === 1'b1 && cmd != CMD_WRITE) flag("dq driven outside a WRITE");
            if (cmd != CMD_NOP) begin
                if (last_cmd != CMD_NOP && cycle - last_cycle < min_gap(last_cmd)) begin
                    flag("command follows the previous one too soon");
                end
                last_cmd   = cmd;
                last_cycle = cycle;
            end
            case (cmd)
                CMD_ACTIVE: begin
                    if (open_q[i_ba]) flag("ACTIVATE to a bank that is already open");
                    open_q[i_ba] = 1'b1;
                    row_q[i_ba]  = i_a;
                end
                CMD_PRECHARGE: begin
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        if (i_a[10] || b == i_ba) open_q[b] = 1'b0;
                    end
                end
                CMD_REFRESH: begin
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        if (open_q[b]) flag("REFRESH while a bank is open");
                    end
                end
                CMD_WRITE: begin
                    if (!open_q[i_ba]) flag("WRITE to a closed bank");
                    if (i_dq_en !== 1'b1) flag("WRITE without dq driven");
                    mem[key] = i_dq;
                end
                CMD_READ: begin
                    if (!open_q[i_ba]) flag("READ from a closed bank");
                    rd_valid[0] <= 1'b1;
                    rd_data[0]  <= mem.exists(key) ? mem[key] : fill_word(key);
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb_sdram_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_controller import sdram_pkg::*; ();

    localparam int NUM_REQ   = 200;
    localparam int REF_LIMIT = REFRESH_INTERVAL + 40;
    // 40 cycles per request plus one refresh sequence per interval
    localparam int TIMEOUT   = NUM_REQ * 40 + (NUM_REQ * 40 / REFRESH_INTERVAL + 1) * 20 + 20;

    logic clk, rst;
    logic cle, cs, ras, cas, we, dq_en;
    logic [BANK_W-1:0] ba;
    logic [ROW_W-1:0]  a;
    logic [DATA_W-1:0] dqo, dqi, data_out, data_in;
    logic [ADDR_W-1:0] user_addr;
    logic rw, in_valid, busy, out_valid, model_err;

    sdram_req_t        req_q [$];       // accepted but not yet on the pins
    logic [DATA_W-1:0] exp_q [$];       // expected read words in order
    int                rd_cycle_q [$];
    logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
    logic              open_tb [NUM_BANKS];
    logic [ROW_W-1:0]  row_tb [NUM_BANKS];
    logic              snap_open [NUM_BANKS];   // bank state at the last access
    logic [ROW_W-1:0]  snap_row [NUM_BANKS];
    int                acts_since, pres_since, cycle, last_ref, rst_end;
    logic              prev_pre_all;

    tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst(rst));

    sdram_controller uut (
        .clk(clk), .rst(rst),
        .o_sdram_cle(cle), .o_sdram_cs(cs), .o_sdram_ras(ras), .o_sdram_cas(cas),
        .o_sdram_we(we), .o_sdram_ba(ba), .o_sdram_a(a), .o_sdram_dqo(dqo),
        .o_sdram_dq_en(dq_en), .i_sdram_dqi(dqi),
        .i_user_addr(user_addr), .i_rw(rw), .i_data_in(data_in), .i_in_valid(in_valid),
        .o_data_out(data_out), .o_busy(busy), .o_out_valid(out_valid)
    );

    sdram_model u_model (
        .clk(clk), .i_cle(cle), .i_cs(cs), .i_ras(ras), .i_cas(cas), .i_we(we),
        .i_ba(ba), .i_a(a), .i_dq(dqo), .i_dq_en(dq_en), .o_dq(dqi), .o_error(model_err)
    );

    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr, addr[8:0]} ^ 32'h5a5a_5a5a;
    endfunction

    task automatic stop_failed();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped after the first failure");
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error %s: expected %0h, actual %0h", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic ensure(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            stop_failed();
        end
    endtask

    task automatic verify_access(input sdram_cmd_e cmd);
        sdram_req_t r;
        ensure(req_q.size() != 0, "READ or WRITE on the pins with no request accepted");
        r = req_q.pop_front();
        compare_value("access command", r.rw ? CMD_WRITE : CMD_READ, cmd);
        compare_value("access bank", r.addr.bank, ba);
        compare_value("access column", r.addr.col, a[9:2]);
        compare_value("open row", r.addr.row, row_tb[ba]);
        if (snap_open[ba] && snap_row[ba] == r.addr.row) begin
            compare_value("row hit activates", 0, acts_since);      // hit
            compare_value("row hit precharges", 0, pres_since);
        end else begin
            compare_value("row miss activates", 1, acts_since);
            compare_value("bank precharges", snap_open[ba] ? 1 : 0, pres_since);
        end
        if (cmd == CMD_READ) rd_cycle_q.push_back(cycle);
        snap_open  = open_tb;
        snap_row   = row_tb;
        acts_since = 0;
        pres_since = 0;
    endtask

    // monitor samples everything on the rising edge
    always @(posedge clk) begin
        sdram_cmd_e cmd;
        sdram_req_t r;
        cmd = sdram_cmd_e'({cs, ras, cas, we});
        cycle++;
        if (cycle >= TIMEOUT) begin
            $display("timeout after %0d cycles", cycle);
            stop_failed();
        end
        ensure(!model_err, "protocol error reported by the SDRAM model");
        if (rst) begin
            last_ref = cycle;
            rst_end  = cycle;
            if (cycle > 1) begin
                compare_value("reset cle", 0, cle);
                compare_value("reset dq_en", 0, dq_en);
                compare_value("reset out_valid", 0, out_valid);
                compare_value("reset busy", 1, busy);
            end
        end else begin
            ensure(cycle - last_ref <= REF_LIMIT, "no refresh within the refresh limit");
            if (cycle - rst_end > 1) begin
                compare_value("cle after reset", 1, cle);
            end
            if (in_valid && !busy) begin
                r.rw   = rw;
                r.addr = sdram_addr_t'(user_addr);
                r.data = data_in;
                req_q.push_back(r);
                if (rw) ref_mem[user_addr] = data_in;
                else exp_q.push_back(ref_mem.exists(user_addr) ? ref_mem[user_addr]
                                                               : fill_word(user_addr));
            end
            case (cmd)
                CMD_ACTIVE: begin
                    acts_since++;
                    open_tb[ba] = 1'b1;
                    row_tb[ba]  = a;
                end
                CMD_PRECHARGE: begin
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        if (a[10] || b == ba) open_tb[b] = 1'b0;
                        if (a[10]) snap_open[b] = 1'b0;   // refresh closes everything
                    end
                    if (!a[10]) pres_since++;
                end
                CMD_REFRESH: begin
                    ensure(prev_pre_all, "REFRESH without a precharge-all before it");
                    last_ref = cycle;
                end
                CMD_READ, CMD_WRITE: verify_access(cmd);
                default: ;
            endcase
            if (cmd != CMD_NOP) prev_pre_all = (cmd == CMD_PRECHARGE) && a[10];
            if (out_valid) begin
                ensure(exp_q.size() != 0, "o_out_valid with no read outstanding");
                compare_value("read data", exp_q.pop_front(), data_out);
                compare_value("read latency", CAS_LATENCY + 1, cycle - rd_cycle_q.pop_front());
            end
        end
    end

    initial begin
        int idle;
        bit hold_junk;
        cycle        = 0;
        last_ref     = 0;
        rst_end      = 0;
        acts_since   = 0;
        pres_since   = 0;
        prev_pre_all = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            open_tb[b]   = 1'b0;
            snap_open[b] = 1'b0;
            row_tb[b]    = '0;
            snap_row[b]  = '0;
        end
        in_valid  = 1'b0;
        rw        = 1'b0;
        user_addr = '0;
        data_in   = '0;
        void'($urandom(37));
        wait (!rst);
        @(negedge clk);
        for (int n = 0; n < NUM_REQ; n++) begin
            hold_junk = ($urandom % 4) == 0;
            idle      = ($urandom % 6) == 0 ? $urandom % 20 : 0;
            // junk is held only while busy so a correct DUT must ignore it
            while (busy) begin
                in_valid  = hold_junk;
                user_addr = ADDR_W'($urandom);
                data_in   = $urandom;
                rw        = 1'($urandom);
                @(negedge clk);
            end
            in_valid = 1'b0;
            repeat (idle) @(negedge clk);
            rw        = 1'($urandom % 2);
            user_addr = {13'($urandom % 3), 2'($urandom % 4), 8'($urandom % 16)};
            data_in   = $urandom;
            in_valid  = 1'b1;
            @(negedge clk);
        end
        in_valid = 1'b0;
        while (req_q.size() != 0 || exp_q.size() != 0) @(negedge clk);
        repeat (CAS_LATENCY + 4) @(negedge clk);
        if (acts_since == 0 && pres_since == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("ACTIVATE or PRECHARGE on the pins after the last access");
            stop_failed();
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
sdram_pkg.sv
sdram_req_latch.sv
sdram_refresh_timer.sv
sdram_bank_tracker.sv
sdram_cmd_sequencer.sv
sdram_phy_regs.sv
sdram_controller.sv
tb_clk_gen.sv
sdram_model.sv
tb_sdram_controller.sv

// ==== Bender.yml ====
package:
  name: sdram_controller

sources:
  - sdram_pkg.sv
  - sdram_req_latch.sv
  - sdram_refresh_timer.sv
  - sdram_bank_tracker.sv
  - sdram_cmd_sequencer.sv
  - sdram_phy_regs.sv
  - sdram_controller.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - sdram_model.sv
      - tb_sdram_controller.sv
